// File: design/freelist_pkg.sv
// **************************************************
// Free list pool definitions
// **************************************************

package freelist_pkg;

  // Number of tags in the pool
  // It must stay above twice the number of allocation ports, since each port
  // can park two tags in its staging register and the pool still has to
  // have tags left to hand out after that
  localparam int NUM_ENTRIES = 16;

  // Number of ports that hand out tags with a valid/ready handshake
  localparam int NUM_ALLOC_PORTS = 2;

  // Number of ports that return tags with a plain valid strobe
  localparam int NUM_DEALLOC_PORTS = 2;

  // Width of a binary tag, log2 of the pool size
  localparam int ENTRY_ID_WIDTH = $clog2(NUM_ENTRIES);

  // A binary tag as it travels on the allocation and deallocation ports
  typedef logic [ENTRY_ID_WIDTH-1:0] entry_id_t;

  // A set of tags with one bit per tag
  // The same type carries the free vector, the masked vector and the one-hot
  // picks, so bit i always stands for tag i
  typedef logic [NUM_ENTRIES-1:0] entry_vec_t;

endpackage

// File: design/free_entry_picker.sv
// **************************************************
// Lowest free tag picker
// **************************************************

`timescale 1ns/1ps

module free_entry_picker (
  input  freelist_pkg::entry_vec_t masked_free,
  output freelist_pkg::entry_vec_t pick_onehot,
  output freelist_pkg::entry_id_t  pick_id,
  output logic                     found
);

  // Isolate the lowest set bit
  // Adding one to the inverted vector carries through the low ones of the
  // inverted value and stops at the first free tag, so the AND keeps only
  // that single bit
  // An all-zero input gives an all-zero pick
  assign pick_onehot = masked_free & (~masked_free + freelist_pkg::entry_vec_t'(1));

  // Any free tag at all means this port has something to stage
  assign found = |masked_free;

  // Turn the one-hot pick into a binary tag
  // Since at most one bit of the pick is set, an OR of the matching indices
  // yields that index and nothing else
  // With no pick the tag reads as zero, which is harmless since found is low
  always_comb begin
    pick_id = '0;
    for (int i = 0; i < freelist_pkg::NUM_ENTRIES; i++) begin
      if (pick_onehot[i]) begin
        pick_id = pick_id | freelist_pkg::entry_id_t'(i);
      end
    end
  end

endmodule

// File: design/alloc_stage_reg.sv
// **************************************************
// Allocation staging register
// **************************************************

`timescale 1ns/1ps

module alloc_stage_reg (
  input  logic                    clk,
  input  logic                    rst_n,

  // Push side, fed from the free vector picker
  input  logic                    push_valid,
  output logic                    push_ready,
  input  freelist_pkg::entry_id_t push_entry_id,

  // Pop side, seen by the consumer as the allocation port
  output logic                    pop_valid,
  input  logic                    pop_ready,
  output freelist_pkg::entry_id_t pop_entry_id
);

  // The main register always holds the oldest staged tag
  // The skid register catches a second tag while the main one is stalled
  logic                    main_valid;
  logic                    skid_valid;
  freelist_pkg::entry_id_t main_id;
  freelist_pkg::entry_id_t skid_id;

  // Handshake completions on either side
  logic push_fire;
  logic pop_fire;

  // Load selects for the two payload registers
  logic main_from_skid;
  logic main_from_push;
  logic skid_from_push;

  logic main_valid_next;
  logic skid_valid_next;

  // Ready comes straight from the skid flag, so the push side sees no
  // combinational path from pop_ready
  // The skid is only ever full while the main register is also full, so
  // an empty skid means fewer than two tags are held
  assign push_ready = !skid_valid;

  // The consumer sees only the main register
  assign pop_valid    = main_valid;
  assign pop_entry_id = main_id;

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = main_valid && pop_ready;

  // When the main tag leaves and a second tag is waiting, the waiting one
  // moves up
  // A push cannot happen in that cycle since the skid was full
  assign main_from_skid = pop_fire && skid_valid;

  // A new tag goes straight to main when main is empty or is being popped
  // in the same cycle, which keeps a full-rate stream free of bubbles
  assign main_from_push = push_fire && (!main_valid || pop_fire);

  // A new tag parks in the skid when main is held by back-pressure
  assign skid_from_push = push_fire && main_valid && !pop_fire;

  always_comb begin
    main_valid_next = main_valid;
    skid_valid_next = skid_valid;

    if (main_from_skid || main_from_push) begin
      main_valid_next = 1'b1;
    end else if (pop_fire) begin
      main_valid_next = 1'b0;
    end

    if (skid_from_push) begin
      skid_valid_next = 1'b1;
    end else if (main_from_skid) begin
      skid_valid_next = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      main_valid <= main_valid_next;
      skid_valid <= skid_valid_next;
    end
  end

  // Tag payloads only load when their valid flag is being set, so the
  // presented tag holds steady for as long as the consumer stalls
  always_ff @(posedge clk) begin
    if (main_from_skid) begin
      main_id <= skid_id;
    end else if (main_from_push) begin
      main_id <= push_entry_id;
    end

    if (skid_from_push) begin
      skid_id <= push_entry_id;
    end
  end

endmodule

// File: design/freelist_manager.sv
// **************************************************
// Free list manager top level
// **************************************************

`timescale 1ns/1ps

module freelist_manager (
  input  logic                                                    clk,
  input  logic                                                    rst_n,

  // Allocation ports, one handshake per port
  output logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                alloc_valid,
  input  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                alloc_ready,
  output freelist_pkg::entry_id_t [freelist_pkg::NUM_ALLOC_PORTS-1:0] alloc_entry_id,

  // Deallocation ports, a plain strobe with no back-pressure
  input  logic [freelist_pkg::NUM_DEALLOC_PORTS-1:0]              dealloc_valid,
  input  freelist_pkg::entry_id_t [freelist_pkg::NUM_DEALLOC_PORTS-1:0] dealloc_entry_id
);

  // Every tag lives in exactly one place at any time
  // It is either in the unstaged free vector, in one of the staging
  // registers, or held by a consumer after allocation
  // Only the first of those is tracked here, the staging registers track
  // the second, and the consumers own the third

  // Tags that are free and not yet parked in any staging register
  freelist_pkg::entry_vec_t unstaged_free;
  freelist_pkg::entry_vec_t unstaged_free_next;

  // Bits to drop this cycle because a stage took the tag
  freelist_pkg::entry_vec_t push_clear;

  // Bits to raise this cycle because a consumer gave the tag back
  freelist_pkg::entry_vec_t dealloc_set;

  // Push side of each staging register
  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                    push_valid;
  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                    push_ready;
  freelist_pkg::entry_id_t [freelist_pkg::NUM_ALLOC_PORTS-1:0] push_entry_id;

  // The same picks in one-hot form, used both for masking lower-priority
  // ports and for clearing the free vector
  freelist_pkg::entry_vec_t [freelist_pkg::NUM_ALLOC_PORTS-1:0] push_onehot;

  for (genvar p = 0; p < freelist_pkg::NUM_ALLOC_PORTS; p++) begin : gen_alloc_port

    // Free tags as this port is allowed to see them
    freelist_pkg::entry_vec_t masked_free;

    // Port 0 sees the whole free vector
    // Every later port loses the tag that each earlier port is about to take,
    // which is what gives the lower port numbers fixed priority
    // An earlier port with a full stage takes nothing, so it masks nothing
    // and its pick stays available to the ports behind it
    always_comb begin
      masked_free = unstaged_free;
      for (int j = 0; j < p; j++) begin
        if (push_ready[j]) begin
          masked_free = masked_free & ~push_onehot[j];
        end
      end
    end

    // The lowest visible tag is offered to this port's stage
    // push_valid drops when a higher port took the last tag, and the offered
    // tag can move down when a lower tag is returned, both without a push
    free_entry_picker u_picker (
      .masked_free (masked_free),
      .pick_onehot (push_onehot[p]),
      .pick_id     (push_entry_id[p]),
      .found       (push_valid[p])
    );

    // Two-deep staging so that a consumer can take a tag every cycle while
    // the pick for the next one is already under way
    alloc_stage_reg u_stage (
      .clk           (clk),
      .rst_n         (rst_n),
      .push_valid    (push_valid[p]),
      .push_ready    (push_ready[p]),
      .push_entry_id (push_entry_id[p]),
      .pop_valid     (alloc_valid[p]),
      .pop_ready     (alloc_ready[p]),
      .pop_entry_id  (alloc_entry_id[p])
    );

  end

  // Collect the tags that move into the staging registers on this edge
  // The masking above guarantees that two ports never push the same tag
  always_comb begin
    push_clear = '0;
    for (int p = 0; p < freelist_pkg::NUM_ALLOC_PORTS; p++) begin
      if (push_valid[p] && push_ready[p]) begin
        push_clear = push_clear | push_onehot[p];
      end
    end
  end

  // Decode the returned tags into a set
  // Each strobe names one held tag, and the user keeps the ports from
  // naming the same tag twice in a cycle
  always_comb begin
    dealloc_set = '0;
    for (int d = 0; d < freelist_pkg::NUM_DEALLOC_PORTS; d++) begin
      if (dealloc_valid[d]) begin
        dealloc_set = dealloc_set | (freelist_pkg::entry_vec_t'(1) << dealloc_entry_id[d]);
      end
    end
  end

  // A returned tag is never free in the same cycle, so it cannot also be
  // in push_clear and the order of set and clear does not matter
  // The returned tag is visible to the pickers right after the edge, so it
  // may be staged again on the next cycle
  assign unstaged_free_next = (unstaged_free | dealloc_set) & ~push_clear;

  // The whole pool starts free with both stages empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      unstaged_free <= '1;
    end else begin
      unstaged_free <= unstaged_free_next;
    end
  end

endmodule

// File: verif/freelist_assert.sv
// **************************************************
// Free list output assertions
// **************************************************

`timescale 1ns/1ps

module freelist_assert (
  input logic                                                        clk,
  input logic                                                        rst_n,
  input logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                    alloc_valid,
  input logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                    alloc_ready,
  input freelist_pkg::entry_id_t [freelist_pkg::NUM_ALLOC_PORTS-1:0] alloc_entry_id
);

  // Running count of failed properties
  int assert_errors = 0;

  // Both stages are empty under reset, so nothing is offered
  reset_quiet: assert property (@(posedge clk) !rst_n |-> alloc_valid == '0)
    else begin
      assert_errors++;
      $error("alloc_valid is high while rst_n is low");
    end

  // A tag sits in exactly one place, so two ports never show the same one
  distinct_offer: assert property (@(posedge clk) disable iff (!rst_n)
    &alloc_valid |-> alloc_entry_id[0] != alloc_entry_id[1])
    else begin
      assert_errors++;
      $error("both allocation ports offer the same tag");
    end

  // A stalled offer keeps its valid and its tag until the consumer takes it
  for (genvar p = 0; p < freelist_pkg::NUM_ALLOC_PORTS; p++) begin : gen_hold
    hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
      alloc_valid[p] && !alloc_ready[p] |=>
        alloc_valid[p] && alloc_entry_id[p] == $past(alloc_entry_id[p]))
      else begin
        assert_errors++;
        $error("port %0d changed its offer while stalled", p);
      end
  end

endmodule

bind freelist_manager freelist_assert u_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .alloc_valid    (alloc_valid),
  .alloc_ready    (alloc_ready),
  .alloc_entry_id (alloc_entry_id)
);

// File: verif/freelist_tb.sv
// **************************************************
// Free list manager testbench
// **************************************************

`timescale 1ns/1ps

module freelist_tb;

  // The watchdog allows twice the sum of these per-test cycle budgets
  localparam int RESET_BUDGET        = 10;
  localparam int DRAIN_BUDGET        = 100;
  localparam int REUSE_BUDGET        = 20;
  localparam int BACKPRESSURE_BUDGET = 250;
  localparam int RANDOM_BUDGET       = 1150;
  localparam int WATCHDOG_CYCLES     = 2 * (RESET_BUDGET + DRAIN_BUDGET + REUSE_BUDGET +
                                            BACKPRESSURE_BUDGET + RANDOM_BUDGET);
  localparam int RANDOM_CYCLES       = 1000;
  // Quiet cycles that mark a drained pool
  localparam int IDLE_LIMIT          = 8;

  logic                                                        clk;
  logic                                                        rst_n;
  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                    alloc_valid;
  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0]                    alloc_ready;
  freelist_pkg::entry_id_t [freelist_pkg::NUM_ALLOC_PORTS-1:0] alloc_entry_id;
  logic [freelist_pkg::NUM_DEALLOC_PORTS-1:0]                  dealloc_valid;
  freelist_pkg::entry_id_t [freelist_pkg::NUM_DEALLOC_PORTS-1:0] dealloc_entry_id;

  // Scoreboard of tags currently held by the consumers
  freelist_pkg::entry_vec_t held;
  // Tags received per port since the last clear
  freelist_pkg::entry_vec_t got_set [freelist_pkg::NUM_ALLOC_PORTS];
  // Outputs as sampled at the falling edge of the last cycle
  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0] samp_valid;
  logic [freelist_pkg::NUM_ALLOC_PORTS-1:0] xfer;
  freelist_pkg::entry_id_t samp_id [freelist_pkg::NUM_ALLOC_PORTS];

  int          idle_cycles;
  int          errors;
  int          checks;
  int          tests_run;
  logic [31:0] lcg_state;

  freelist_manager dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .alloc_valid      (alloc_valid),
    .alloc_ready      (alloc_ready),
    .alloc_entry_id   (alloc_entry_id),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [15:0] lcg_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("Error at time %0t: %s", $time, msg);
  endtask

  task automatic check_entry(input freelist_pkg::entry_id_t got,
                             input freelist_pkg::entry_id_t expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at time %0t: %s got %0d expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic check_set(input freelist_pkg::entry_vec_t got,
                           input freelist_pkg::entry_vec_t expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic check_flags(input logic [freelist_pkg::NUM_ALLOC_PORTS-1:0] got,
                             input logic [freelist_pkg::NUM_ALLOC_PORTS-1:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at time %0t: %s got %b expected %b", $time, what, got, expected);
    end
  endtask

  // Sample at the falling edge, where inputs and outputs both hold the
  // values that the next rising edge acts on, then drive 1 ns after it
  task automatic step_cycle();
    @(negedge clk);
    samp_valid = alloc_valid;
    xfer = alloc_valid & alloc_ready;
    for (int p = 0; p < freelist_pkg::NUM_ALLOC_PORTS; p++) begin
      samp_id[p] = alloc_entry_id[p];
      if (xfer[p]) begin
        if (held[samp_id[p]]) begin
          report_failure($sformatf("tag %0d allocated on port %0d while held", samp_id[p], p));
        end
        held[samp_id[p]] = 1'b1;
        got_set[p][samp_id[p]] = 1'b1;
      end
    end
    // Allocation and return of one tag never meet on the same edge
    for (int d = 0; d < freelist_pkg::NUM_DEALLOC_PORTS; d++) begin
      if (dealloc_valid[d]) begin
        held[dealloc_entry_id[d]] = 1'b0;
      end
    end
    idle_cycles = (xfer == '0) ? idle_cycles + 1 : 0;
    @(posedge clk);
    #1;
  endtask

  task automatic drain_until_idle(input int budget, input string what);
    int n;
    n = 0;
    idle_cycles = 0;
    while (idle_cycles < IDLE_LIMIT && n < budget) begin
      step_cycle();
      n++;
    end
    if (idle_cycles < IDLE_LIMIT) begin
      report_failure($sformatf("%s kept allocating after %0d cycles", what, budget));
    end
  endtask

  task automatic clear_received();
    foreach (got_set[p]) begin
      got_set[p] = '0;
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    alloc_ready = '0;
    dealloc_valid = '0;
    repeat (4) step_cycle();
    rst_n = 1'b1;
    held = '0;
  endtask

  task automatic print_test_result(input string name, input int errors_at_start);
    tests_run++;
    $display("%s finished at time %0t with %0d errors", name, $time, errors - errors_at_start);
  endtask

  task automatic reset_state_test();
    int errors_at_start;
    int n;
    errors_at_start = errors;
    repeat (4) begin
      step_cycle();
      check_flags(samp_valid, '0, "alloc_valid during reset");
    end
    rst_n = 1'b1;
    n = 0;
    while (samp_valid != '1 && n < 2) begin
      step_cycle();
      n++;
    end
    if (samp_valid != '1) begin
      report_failure("allocation ports not both valid two cycles after reset");
    end else begin
      // Port 0 takes the lowest free tag, port 1 the next one
      check_entry(samp_id[0], 0, "first tag on port 0");
      check_entry(samp_id[1], 1, "first tag on port 1");
    end
    print_test_result("reset_state", errors_at_start);
  endtask

  task automatic drain_test();
    int errors_at_start;
    errors_at_start = errors;
    clear_received();
    alloc_ready = '1;
    drain_until_idle(DRAIN_BUDGET, "drain");
    check_set(got_set[0] | got_set[1], '1, "tags received during drain");
    check_set(held, '1, "held set after drain");
    check_flags(samp_valid, '0, "alloc_valid after drain");
    print_test_result("drain", errors_at_start);
  endtask

  task automatic reuse_test();
    int errors_at_start;
    freelist_pkg::entry_id_t expected [freelist_pkg::NUM_ALLOC_PORTS];
    freelist_pkg::entry_vec_t returned;
    errors_at_start = errors;
    dealloc_valid = '1;
    dealloc_entry_id[0] = 4'd5;
    dealloc_entry_id[1] = 4'd11;
    returned = (freelist_pkg::entry_vec_t'(1) << 5) | (freelist_pkg::entry_vec_t'(1) << 11);
    // Priority hands the lower returned tag to port 0
    expected[0] = 4'd5;
    expected[1] = 4'd11;
    step_cycle();
    dealloc_valid = '0;
    clear_received();
    repeat (IDLE_LIMIT) begin
      step_cycle();
      for (int p = 0; p < freelist_pkg::NUM_ALLOC_PORTS; p++) begin
        if (xfer[p]) begin
          check_entry(samp_id[p], expected[p], $sformatf("reused tag on port %0d", p));
        end
      end
    end
    check_set(got_set[0] | got_set[1], returned, "reused tags");
    check_set(held, '1, "held set after reuse");
    check_flags(samp_valid, '0, "alloc_valid after reuse");
    print_test_result("return_reuse", errors_at_start);
  endtask

  task automatic backpressure_test();
    int errors_at_start;
    int n;
    freelist_pkg::entry_vec_t parked;
    errors_at_start = errors;
    apply_reset();
    clear_received();
    alloc_ready = 2'b01;
    // Both stages fill on the first two edges after reset with port 0 taking
    // the lower tag each time, so port 1 ends up holding tags 1 and 3
    parked = (freelist_pkg::entry_vec_t'(1) << 1) | (freelist_pkg::entry_vec_t'(1) << 3);
    n = 0;
    idle_cycles = 0;
    while (idle_cycles < IDLE_LIMIT && n < DRAIN_BUDGET) begin
      step_cycle();
      n++;
      // The oldest parked tag stays on port 1 for as long as it is stalled
      if (samp_valid[1]) begin
        check_entry(samp_id[1], 4'd1, "stalled tag on port 1");
      end
    end
    if (idle_cycles < IDLE_LIMIT) begin
      report_failure("port 0 kept allocating under port 1 back-pressure");
    end
    check_flags(samp_valid, 2'b10, "alloc_valid under back-pressure");
    // Port 1 parks two tags, port 0 gets all the others
    check_set(~got_set[0], parked, "tags left over by port 0");
    clear_received();
    alloc_ready = '1;
    drain_until_idle(DRAIN_BUDGET, "port 1 release");
    check_set(got_set[1], parked, "tags delivered by port 1");
    check_set(held, '1, "held set after back-pressure");
    print_test_result("backpressure", errors_at_start);
  endtask

  task automatic random_mix_test();
    int errors_at_start;
    logic [15:0] r;
    logic picked;
    freelist_pkg::entry_vec_t pending;
    freelist_pkg::entry_id_t start;
    freelist_pkg::entry_id_t cand;
    errors_at_start = errors;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      r = lcg_rand();
      alloc_ready = r[1:0];
      pending = '0;
      for (int d = 0; d < freelist_pkg::NUM_DEALLOC_PORTS; d++) begin
        dealloc_valid[d] = 1'b0;
        if (r[2 + d]) begin
          // Walk up from a random tag to the first held one not yet taken
          start = freelist_pkg::entry_id_t'(lcg_rand());
          picked = 1'b0;
          for (int k = 0; k < freelist_pkg::NUM_ENTRIES; k++) begin
            cand = start + freelist_pkg::entry_id_t'(k);
            if (!picked && held[cand] && !pending[cand]) begin
              picked = 1'b1;
              pending[cand] = 1'b1;
              dealloc_valid[d] = 1'b1;
              dealloc_entry_id[d] = cand;
            end
          end
        end
      end
      step_cycle();
    end
    dealloc_valid = '0;
    alloc_ready = '1;
    drain_until_idle(DRAIN_BUDGET, "final drain");
    check_set(held, '1, "held set after random mix");
    print_test_result("random_mix", errors_at_start);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    alloc_ready = '0;
    dealloc_valid = '0;
    dealloc_entry_id = '0;
    held = '0;
    samp_valid = '0;
    xfer = '0;
    idle_cycles = 0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    lcg_state = 32'd41955;
    clear_received();

    reset_state_test();
    drain_test();
    reuse_test();
    backpressure_test();
    random_mix_test();

    errors = errors + dut_i.u_assert.assert_errors;
    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: all.f
design/freelist_pkg.sv
design/free_entry_picker.sv
design/alloc_stage_reg.sv
design/freelist_manager.sv
verif/freelist_assert.sv
verif/freelist_tb.sv

// File: Makefile
# Verilator build and run of the free list manager testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module freelist_tb -f all.f
	@out="$$(./obj_dir/Vfreelist_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
